// ==== hw/rv_isa_pkg.sv ====
package rv_isa_pkg;

    // Major opcodes, instruction bits [6:0]
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL,
        ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU, ALU_COPY_B
    } alu_op_e;

    // Branch conditions
    localparam logic [2:0] FUNCT3_BEQ  = 3'b000;
    localparam logic [2:0] FUNCT3_BNE  = 3'b001;
    localparam logic [2:0] FUNCT3_BLT  = 3'b100;
    localparam logic [2:0] FUNCT3_BGE  = 3'b101;
    localparam logic [2:0] FUNCT3_BLTU = 3'b110;
    localparam logic [2:0] FUNCT3_BGEU = 3'b111;

    // Arithmetic and logic ops
    localparam logic [2:0] FUNCT3_ADD  = 3'b000;
    localparam logic [2:0] FUNCT3_SLL  = 3'b001;
    localparam logic [2:0] FUNCT3_SLT  = 3'b010;
    localparam logic [2:0] FUNCT3_SLTU = 3'b011;
    localparam logic [2:0] FUNCT3_XOR  = 3'b100;
    localparam logic [2:0] FUNCT3_SR   = 3'b101;
    localparam logic [2:0] FUNCT3_OR   = 3'b110;
    localparam logic [2:0] FUNCT3_AND  = 3'b111;

    // Selects sub and sra
    localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

    // addi x0, x0, 0
    localparam logic [31:0] NOP_INSTR = 32'h0000_0013;

endpackage

// ==== hw/core_pkg.sv ====
package core_pkg;

    localparam int XLEN = 32;
    localparam int REG_AWIDTH = 5;
    localparam logic [XLEN-1:0] RESET_PC = '0;

    typedef enum logic [1:0] {PC_PLUS4, PC_JAL, PC_X} pc_sel_e;
    typedef enum logic [1:0] {WB_MEM, WB_ALU, WB_LINK} wb_sel_e;
    typedef enum logic [1:0] {FWD_NONE, FWD_X, FWD_WB} fwd_sel_e;

    // All zeros is a bubble
    typedef struct packed {
        rv_isa_pkg::alu_op_e alu_op;
        logic                a_sel_pc;
        logic                b_sel_imm;
        logic                br_un;
        logic                is_branch;
        logic                is_jalr;
        logic                mem_write;
        logic                mem_read;
        logic                reg_wen;
        wb_sel_e             wb_sel;
        logic [2:0]          funct3;
    } ctrl_t;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       rs1_data;
        logic [XLEN-1:0]       rs2_data;
        logic [XLEN-1:0]       imm;
        ctrl_t                 ctrl;
        logic [REG_AWIDTH-1:0] rd;
        logic [REG_AWIDTH-1:0] rs1;
        logic [REG_AWIDTH-1:0] rs2;
    } id_x_t;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       alu_res;
        ctrl_t                 ctrl;
        logic [REG_AWIDTH-1:0] rd;
    } x_wb_t;

endpackage

// ==== hw/control_decoder.sv ====
`timescale 1ns/1ps

module control_decoder (
    input  logic [31:0]     instr,
    output core_pkg::ctrl_t ctrl,
    output logic [31:0]     imm
);
    import rv_isa_pkg::*;
    import core_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    alu_op_e    alu_fn;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;

    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // Shared by register and immediate forms; only the register form has sub
    always_comb begin
        case (funct3)
            FUNCT3_ADD: begin
                if (opcode == OPC_OP && funct7 == FUNCT7_ALT) alu_fn = ALU_SUB;
                else alu_fn = ALU_ADD;
            end
            FUNCT3_SR: begin
                if (funct7 == FUNCT7_ALT) alu_fn = ALU_SRA;
                else alu_fn = ALU_SRL;
            end
            FUNCT3_SLL:  alu_fn = ALU_SLL;
            FUNCT3_SLT:  alu_fn = ALU_SLT;
            FUNCT3_SLTU: alu_fn = ALU_SLTU;
            FUNCT3_XOR:  alu_fn = ALU_XOR;
            FUNCT3_OR:   alu_fn = ALU_OR;
            default:     alu_fn = ALU_AND;
        endcase
    end

    always_comb begin
        ctrl = '0;
        imm = '0;
        case (opcode)
            OPC_OP: begin
                ctrl.alu_op = alu_fn;
                ctrl.reg_wen = 1'b1;
                ctrl.wb_sel = WB_ALU;
            end
            OPC_OP_IMM: begin
                ctrl.alu_op = alu_fn;
                ctrl.b_sel_imm = 1'b1;
                ctrl.reg_wen = 1'b1;
                ctrl.wb_sel = WB_ALU;
                imm = imm_i;
            end
            OPC_LUI, OPC_AUIPC: begin
                ctrl.alu_op = (opcode == OPC_LUI) ? ALU_COPY_B : ALU_ADD;
                ctrl.a_sel_pc = 1'b1;
                ctrl.b_sel_imm = 1'b1;
                ctrl.reg_wen = 1'b1;
                ctrl.wb_sel = WB_ALU;
                imm = imm_u;
            end
            OPC_JAL: begin
                // Redirect happens in ID, X only writes the link
                ctrl.reg_wen = 1'b1;
                ctrl.wb_sel = WB_LINK;
                imm = imm_j;
            end
            OPC_JALR: begin
                ctrl.alu_op = ALU_ADD;
                ctrl.b_sel_imm = 1'b1;
                ctrl.is_jalr = 1'b1;
                ctrl.reg_wen = 1'b1;
                ctrl.wb_sel = WB_LINK;
                imm = imm_i;
            end
            OPC_BRANCH: begin
                ctrl.alu_op = ALU_ADD;
                ctrl.a_sel_pc = 1'b1;
                ctrl.b_sel_imm = 1'b1;
                ctrl.is_branch = 1'b1;
                ctrl.br_un = funct3[1];
                ctrl.funct3 = funct3;
                imm = imm_b;
            end
            OPC_LOAD: begin
                ctrl.alu_op = ALU_ADD;
                ctrl.b_sel_imm = 1'b1;
                ctrl.mem_read = 1'b1;
                ctrl.reg_wen = 1'b1;
                ctrl.wb_sel = WB_MEM;
                imm = imm_i;
            end
            OPC_STORE: begin
                ctrl.alu_op = ALU_ADD;
                ctrl.b_sel_imm = 1'b1;
                ctrl.mem_write = 1'b1;
                imm = imm_s;
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

endmodule

// ==== hw/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic                            clk,
    input  logic [core_pkg::REG_AWIDTH-1:0] ra1,
    input  logic [core_pkg::REG_AWIDTH-1:0] ra2,
    output logic [core_pkg::XLEN-1:0]       rd1,
    output logic [core_pkg::XLEN-1:0]       rd2,
    input  logic [core_pkg::REG_AWIDTH-1:0] wa,
    input  logic [core_pkg::XLEN-1:0]       wd,
    input  logic                            we
);
    import core_pkg::*;

    logic [XLEN-1:0] regs [2**REG_AWIDTH];

    always_ff @(posedge clk) begin
        if (we && wa != '0) begin
            regs[wa] <= wd;
        end
    end

    // x0 is hardwired
    assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

// ==== hw/forward_unit.sv ====
`timescale 1ns/1ps

module forward_unit (
    input  logic [core_pkg::REG_AWIDTH-1:0] rs1_id,
    input  logic [core_pkg::REG_AWIDTH-1:0] rs2_id,
    input  logic [core_pkg::REG_AWIDTH-1:0] rs1_x,
    input  logic [core_pkg::REG_AWIDTH-1:0] rs2_x,
    input  logic [core_pkg::REG_AWIDTH-1:0] rd_x,
    input  logic [core_pkg::REG_AWIDTH-1:0] rd_wb,
    input  logic                            wen_x,
    input  logic                            wen_wb,
    input  logic                            mem_read_x,
    output core_pkg::fwd_sel_e              fwd_id_a,
    output core_pkg::fwd_sel_e              fwd_id_b,
    output core_pkg::fwd_sel_e              fwd_x_a,
    output core_pkg::fwd_sel_e              fwd_x_b
);
    import core_pkg::*;

    logic x_hit;
    logic wb_hit;

    // Load data is not ready while the load sits in X
    assign x_hit = wen_x && !mem_read_x && rd_x != '0;
    assign wb_hit = wen_wb && rd_wb != '0;

    always_comb begin
        fwd_id_a = FWD_NONE;
        fwd_id_b = FWD_NONE;
        fwd_x_a = FWD_NONE;
        fwd_x_b = FWD_NONE;
        // Youngest producer first
        if (x_hit && rd_x == rs1_id) fwd_id_a = FWD_X;
        else if (wb_hit && rd_wb == rs1_id) fwd_id_a = FWD_WB;
        if (x_hit && rd_x == rs2_id) fwd_id_b = FWD_X;
        else if (wb_hit && rd_wb == rs2_id) fwd_id_b = FWD_WB;
        if (wb_hit && rd_wb == rs1_x) fwd_x_a = FWD_WB;
        if (wb_hit && rd_wb == rs2_x) fwd_x_b = FWD_WB;
    end

endmodule

// ==== hw/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  logic [core_pkg::XLEN-1:0] a,
    input  logic [core_pkg::XLEN-1:0] b,
    input  rv_isa_pkg::alu_op_e       op,
    output logic [core_pkg::XLEN-1:0] res
);
    import rv_isa_pkg::*;
    import core_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            ALU_ADD:    res = a + b;
            ALU_SUB:    res = a - b;
            ALU_AND:    res = a & b;
            ALU_OR:     res = a | b;
            ALU_XOR:    res = a ^ b;
            ALU_SLL:    res = a << shamt;
            ALU_SRL:    res = a >> shamt;
            ALU_SRA:    res = $signed(a) >>> shamt;
            ALU_SLT:    res = ($signed(a) < $signed(b)) ? XLEN'(1) : '0;
            ALU_SLTU:   res = (a < b) ? XLEN'(1) : '0;
            ALU_COPY_B: res = b;
            default:    res = '0;
        endcase
    end

endmodule

// ==== hw/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
    input  core_pkg::id_x_t           id_x,
    input  logic [core_pkg::XLEN-1:0] wb_res,
    input  core_pkg::fwd_sel_e        fwd_a,
    input  core_pkg::fwd_sel_e        fwd_b,
    input  logic                      kill,
    output core_pkg::pc_sel_e         pc_sel,
    output logic [core_pkg::XLEN-1:0] target,
    output core_pkg::x_wb_t           x_wb,
    output logic [core_pkg::XLEN-1:0] alu_res,
    output logic [core_pkg::XLEN-1:0] dmem_addr,
    output logic [core_pkg::XLEN-1:0] dmem_wdata,
    output logic                      dmem_we,
    output logic                      dmem_re
);
    import rv_isa_pkg::*;
    import core_pkg::*;

    ctrl_t           ctrl;
    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_out;
    logic            br_eq;
    logic            br_lt;
    logic            br_taken;

    // Wrong-path instruction becomes a bubble
    assign ctrl = kill ? '0 : id_x.ctrl;

    // Anything newer than WB was already forwarded in ID
    assign rs1_val = (fwd_a == FWD_WB) ? wb_res : id_x.rs1_data;
    assign rs2_val = (fwd_b == FWD_WB) ? wb_res : id_x.rs2_data;
    assign op_a = ctrl.a_sel_pc ? id_x.pc : rs1_val;
    assign op_b = ctrl.b_sel_imm ? id_x.imm : rs2_val;

    alu alu0 (
        .a   (op_a),
        .b   (op_b),
        .op  (ctrl.alu_op),
        .res (alu_out)
    );

    ////////////////////
    // Branch and redirect
    ////////////////////
    assign br_eq = (rs1_val == rs2_val);
    assign br_lt = ctrl.br_un ? (rs1_val < rs2_val) : ($signed(rs1_val) < $signed(rs2_val));

    always_comb begin
        case (ctrl.funct3)
            FUNCT3_BEQ:              br_taken = br_eq;
            FUNCT3_BNE:              br_taken = !br_eq;
            FUNCT3_BLT, FUNCT3_BLTU: br_taken = br_lt;
            FUNCT3_BGE, FUNCT3_BGEU: br_taken = !br_lt;
            default:                 br_taken = 1'b0;
        endcase
    end

    always_comb begin
        if (ctrl.is_jalr || (ctrl.is_branch && br_taken)) pc_sel = PC_X;
        else pc_sel = PC_PLUS4;
    end

    assign target = ctrl.is_jalr ? {alu_out[XLEN-1:1], 1'b0} : alu_out;

    // Value seen by ID forwarding, link for jumps
    assign alu_res = (ctrl.wb_sel == WB_LINK) ? id_x.pc + XLEN'(4) : alu_out;
    assign x_wb = '{pc: id_x.pc, alu_res: alu_res, ctrl: ctrl, rd: id_x.rd};

    assign dmem_addr = alu_out;
    assign dmem_wdata = rs2_val;
    assign dmem_we = ctrl.mem_write;
    assign dmem_re = ctrl.mem_read;

endmodule

// ==== hw/riscv_core.sv ====
`timescale 1ns/1ps

module riscv_core (
    input  logic                      clk,
    input  logic                      rst,
    output logic [core_pkg::XLEN-1:0] imem_addr,
    input  logic [core_pkg::XLEN-1:0] imem_rdata,
    output logic [core_pkg::XLEN-1:0] dmem_addr,
    output logic [core_pkg::XLEN-1:0] dmem_wdata,
    output logic                      dmem_we,
    output logic                      dmem_re,
    input  logic [core_pkg::XLEN-1:0] dmem_rdata
);
    import rv_isa_pkg::*;
    import core_pkg::*;

    logic [XLEN-1:0] pc_if;
    logic [XLEN-1:0] pc_next;
    logic [XLEN-1:0] pc_id;
    pc_sel_e         pc_sel;
    pc_sel_e         x_pc_sel;
    logic [XLEN-1:0] x_target;
    logic            id_valid;
    logic            kill_jal_q;
    logic            redirect_q;
    logic            jal_id;
    logic [XLEN-1:0] instr_id;
    ctrl_t           ctrl_id;
    logic [XLEN-1:0] imm_id;
    logic [XLEN-1:0] rf_rd1;
    logic [XLEN-1:0] rf_rd2;
    fwd_sel_e        fwd_id_a;
    fwd_sel_e        fwd_id_b;
    fwd_sel_e        fwd_x_a;
    fwd_sel_e        fwd_x_b;
    logic [XLEN-1:0] x_res;
    logic [XLEN-1:0] wb_res;
    id_x_t           id_x_d;
    id_x_t           id_x_q;
    x_wb_t           x_wb_d;
    x_wb_t           x_wb_q;

    function automatic logic [XLEN-1:0] fwd_mux(fwd_sel_e sel, logic [XLEN-1:0] rf_val,
                                                logic [XLEN-1:0] x_val,
                                                logic [XLEN-1:0] wb_val);
        case (sel)
            FWD_X:   return x_val;
            FWD_WB:  return wb_val;
            default: return rf_val;
        endcase
    endfunction

    ////////////////////
    // Fetch
    ////////////////////
    assign imem_addr = pc_if;

    // X redirect wins over a JAL in ID
    always_comb begin
        if (x_pc_sel == PC_X) pc_sel = PC_X;
        else if (jal_id) pc_sel = PC_JAL;
        else pc_sel = PC_PLUS4;
        case (pc_sel)
            PC_JAL:  pc_next = pc_id + imm_id;
            PC_X:    pc_next = x_target;
            default: pc_next = pc_if + XLEN'(4);
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_if <= RESET_PC;
            id_valid <= 1'b0;
            kill_jal_q <= 1'b0;
            redirect_q <= 1'b0;
        end else begin
            pc_if <= pc_next;
            id_valid <= 1'b1;
            kill_jal_q <= (pc_sel == PC_JAL);
            redirect_q <= (pc_sel == PC_X);
        end
    end

    always_ff @(posedge clk) begin
        pc_id <= pc_if;
    end

    ////////////////////
    // Decode
    ////////////////////
    assign instr_id = (!id_valid || kill_jal_q || redirect_q) ? NOP_INSTR : imem_rdata;
    assign jal_id = (opcode_e'(instr_id[6:0]) == OPC_JAL);

    control_decoder dec0 (
        .instr (instr_id),
        .ctrl  (ctrl_id),
        .imm   (imm_id)
    );

    reg_file rf0 (
        .clk (clk),
        .ra1 (instr_id[19:15]),
        .ra2 (instr_id[24:20]),
        .rd1 (rf_rd1),
        .rd2 (rf_rd2),
        .wa  (x_wb_q.rd),
        .wd  (wb_res),
        .we  (x_wb_q.ctrl.reg_wen)
    );

    // X-side hazard info comes after the kill
    forward_unit fwd0 (
        .rs1_id     (instr_id[19:15]),
        .rs2_id     (instr_id[24:20]),
        .rs1_x      (id_x_q.rs1),
        .rs2_x      (id_x_q.rs2),
        .rd_x       (x_wb_d.rd),
        .rd_wb      (x_wb_q.rd),
        .wen_x      (x_wb_d.ctrl.reg_wen),
        .wen_wb     (x_wb_q.ctrl.reg_wen),
        .mem_read_x (x_wb_d.ctrl.mem_read),
        .fwd_id_a   (fwd_id_a),
        .fwd_id_b   (fwd_id_b),
        .fwd_x_a    (fwd_x_a),
        .fwd_x_b    (fwd_x_b)
    );

    assign id_x_d = '{
        pc:       pc_id,
        rs1_data: fwd_mux(fwd_id_a, rf_rd1, x_res, wb_res),
        rs2_data: fwd_mux(fwd_id_b, rf_rd2, x_res, wb_res),
        imm:      imm_id,
        ctrl:     ctrl_id,
        rd:       instr_id[11:7],
        rs1:      instr_id[19:15],
        rs2:      instr_id[24:20]
    };

    ////////////////////
    // Execute
    ////////////////////
    execute_stage ex0 (
        .id_x       (id_x_q),
        .wb_res     (wb_res),
        .fwd_a      (fwd_x_a),
        .fwd_b      (fwd_x_b),
        .kill       (redirect_q),
        .pc_sel     (x_pc_sel),
        .target     (x_target),
        .x_wb       (x_wb_d),
        .alu_res    (x_res),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_re    (dmem_re)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            id_x_q <= '0;
            x_wb_q <= '0;
        end else begin
            id_x_q <= id_x_d;
            x_wb_q <= x_wb_d;
        end
    end

    ////////////////////
    // Write-back
    ////////////////////
    always_comb begin
        case (x_wb_q.ctrl.wb_sel)
            WB_ALU:  wb_res = x_wb_q.alu_res;
            WB_LINK: wb_res = x_wb_q.pc + XLEN'(4);
            default: wb_res = dmem_rdata;
        endcase
    end

endmodule

// ==== verif/test_programs.svh ====
`ifndef TEST_PROGRAMS_SVH
`define TEST_PROGRAMS_SVH

localparam int NUM_TESTS = 6;
localparam int MAX_WORDS = 24;
localparam int MAX_STORES = 10;

typedef struct packed {
    logic [31:0] addr;
    logic [31:0] data;
} store_t;

string       test_names [NUM_TESTS];
logic [31:0] progs [NUM_TESTS][MAX_WORDS];
int          prog_lens [NUM_TESTS];
store_t      exp_stores [NUM_TESTS][MAX_STORES];
int          exp_counts [NUM_TESTS];
int          cur;

////////////////////
// Instruction encoders
////////////////////
function automatic logic [31:0] op_rr(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
                                      logic [4:0] rs1, logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] enc_i(logic [31:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                      logic [4:0] rd, logic [6:0] opc);
    return {imm[11:0], rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] op_ri(logic [2:0] f3, logic [4:0] rd, logic [4:0] rs1,
                                      logic [31:0] imm);
    return enc_i(imm, rs1, f3, rd, 7'b0010011);
endfunction

function automatic logic [31:0] lw_w(logic [4:0] rd, logic [4:0] rs1, logic [31:0] off);
    return enc_i(off, rs1, 3'b010, rd, 7'b0000011);
endfunction

function automatic logic [31:0] jalr_w(logic [4:0] rd, logic [4:0] rs1, logic [31:0] off);
    return enc_i(off, rs1, 3'b000, rd, 7'b1100111);
endfunction

function automatic logic [31:0] sw_w(logic [4:0] rs2, logic [4:0] rs1, logic [31:0] off);
    return {off[11:5], rs2, rs1, 3'b010, off[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] br(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                   logic [31:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
endfunction

function automatic logic [31:0] jal_w(logic [4:0] rd, logic [31:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
endfunction

function automatic logic [31:0] upper(logic [19:0] imm, logic [4:0] rd, logic [6:0] opc);
    return {imm, rd, opc};
endfunction

task automatic emit(input logic [31:0] word);
    progs[cur][prog_lens[cur]] = word;
    prog_lens[cur]++;
endtask

task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
    exp_stores[cur][exp_counts[cur]] = '{addr: addr, data: data};
    exp_counts[cur]++;
endtask

task automatic start_test(input int idx, input string name);
    cur = idx;
    test_names[idx] = name;
    prog_lens[idx] = 0;
    exp_counts[idx] = 0;
endtask
`endif

// ==== verif/riscv_core_tb.sv ====
`timescale 1ns/1ps

module riscv_core_tb;

    logic        clk;
    logic        rst;
    logic [31:0] imem_addr;
    logic [31:0] imem_rdata;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic        dmem_we;
    logic        dmem_re;
    logic [31:0] dmem_rdata;

    `include "test_programs.svh"

    logic [31:0] cur_prog [MAX_WORDS];
    int          cur_len;
    logic [31:0] dmem [256];
    logic [31:0] ia_q;
    logic [31:0] da_q;
    logic        re_q;
    store_t      seen [$];
    int          test_errors;
    int          passed;
    int          failed;

    riscv_core dut0 (
        .clk        (clk),
        .rst        (rst),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_re    (dmem_re),
        .dmem_rdata (dmem_rdata)
    );

    always #2 clk = ~clk;

    ////////////////////
    // Memory models
    ////////////////////
    function automatic logic [31:0] fetch_word(logic [31:0] addr);
        // Past the program the core spins on jal x0, 0
        if (addr < cur_len * 4) return cur_prog[addr[31:2]];
        return 32'h0000_006f;
    endfunction

    always @(negedge clk) begin
        ia_q = imem_addr;
        da_q = dmem_addr;
        re_q = (dmem_re === 1'b1);
        if (!rst && dmem_we === 1'b1) begin
            dmem[dmem_addr[9:2]] = dmem_wdata;
            seen.push_back('{addr: dmem_addr, data: dmem_wdata});
        end
    end

    always @(posedge clk) begin
        #1;
        imem_rdata = fetch_word(ia_q);
        // Read data only follows a cycle with a load request
        dmem_rdata = re_q ? dmem[da_q[9:2]] : 'x;
    end

    task automatic check_value(input string name, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Error %s: %s expected %h, actual %h", name, what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic reset_and_load(input int t);
        @(posedge clk);
        #1 rst = 1'b1;
        for (int i = 0; i < MAX_WORDS; i++) begin
            cur_prog[i] = progs[t][i];
        end
        cur_len = prog_lens[t];
        // Distinct background word at every address
        for (int i = 0; i < 256; i++) begin
            dmem[i] = 32'h5a00_0000 ^ (i * 4);
        end
        seen.delete();
        repeat (5) @(posedge clk);
        #1 rst = 1'b0;
        // Core state right after reset
        check_value(test_names[t], "imem_addr after reset", 32'h0000_0000, imem_addr);
        check_value(test_names[t], "dmem_we after reset", 32'h0000_0000, dmem_we);
        check_value(test_names[t], "dmem_re after reset", 32'h0000_0000, dmem_re);
    endtask

    task automatic build_tests();
        // Dependent chain forwarded from X and WB
        start_test(0, "alu_rr");
        emit(op_ri(3'b000, 1, 0, 7));
        emit(op_ri(3'b000, 2, 0, -3));
        emit(op_rr(7'h00, 3'b000, 3, 1, 2));
        emit(op_rr(7'h20, 3'b000, 4, 3, 1));
        emit(op_rr(7'h00, 3'b111, 5, 4, 1));
        emit(op_rr(7'h00, 3'b110, 6, 5, 2));
        emit(op_rr(7'h00, 3'b100, 7, 6, 1));
        emit(op_rr(7'h00, 3'b001, 8, 1, 3));
        emit(op_rr(7'h00, 3'b101, 9, 2, 3));
        emit(op_rr(7'h20, 3'b101, 10, 2, 3));
        emit(op_rr(7'h00, 3'b010, 11, 2, 1));
        emit(op_rr(7'h00, 3'b011, 12, 2, 1));
        for (int r = 3; r <= 12; r++) begin
            emit(sw_w(r, 0, 32'h100 + (r - 3) * 4));
        end
        expect_store(32'h100, 32'h0000_0004);
        expect_store(32'h104, 32'hffff_fffd);
        expect_store(32'h108, 32'h0000_0005);
        expect_store(32'h10c, 32'hffff_fffd);
        expect_store(32'h110, 32'hffff_fffa);
        expect_store(32'h114, 32'h0000_0070);
        expect_store(32'h118, 32'h0fff_ffff);
        expect_store(32'h11c, 32'hffff_ffff);
        expect_store(32'h120, 32'h0000_0001);
        expect_store(32'h124, 32'h0000_0000);

        start_test(1, "imm_ops");
        emit(op_ri(3'b000, 1, 0, 32'h7f0));
        emit(op_ri(3'b100, 2, 1, -1));
        emit(op_ri(3'b110, 3, 1, 32'h00f));
        emit(op_ri(3'b111, 4, 2, 32'h0ff));
        emit(op_ri(3'b001, 5, 1, 20));
        emit(op_ri(3'b101, 6, 2, 32'h404));
        emit(op_ri(3'b101, 7, 2, 28));
        emit(op_ri(3'b010, 8, 2, 0));
        emit(op_ri(3'b011, 9, 1, -1));
        emit(upper(20'h12345, 10, 7'b0110111));
        // auipc at byte 40
        emit(upper(20'h00001, 11, 7'b0010111));
        for (int r = 2; r <= 11; r++) begin
            emit(sw_w(r, 0, 32'h140 + (r - 2) * 4));
        end
        expect_store(32'h140, 32'hffff_f80f);
        expect_store(32'h144, 32'h0000_07ff);
        expect_store(32'h148, 32'h0000_000f);
        expect_store(32'h14c, 32'h7f00_0000);
        expect_store(32'h150, 32'hffff_ff80);
        expect_store(32'h154, 32'h0000_000f);
        expect_store(32'h158, 32'h0000_0001);
        expect_store(32'h15c, 32'h0000_0001);
        expect_store(32'h160, 32'h1234_5000);
        expect_store(32'h164, 32'h0000_1028);

        start_test(2, "load_use");
        emit(op_ri(3'b000, 1, 0, 32'h5a));
        emit(sw_w(1, 0, 32'h200));
        emit(lw_w(2, 0, 32'h200));
        emit(op_rr(7'h00, 3'b000, 3, 2, 1));
        emit(sw_w(3, 0, 32'h204));
        emit(lw_w(4, 0, 32'h204));
        emit(sw_w(4, 0, 32'h208));
        expect_store(32'h200, 32'h0000_005a);
        expect_store(32'h204, 32'h0000_00b4);
        expect_store(32'h208, 32'h0000_00b4);

        // Taken branches jump over a trap store to 0x3f0
        start_test(3, "branch_signed");
        emit(op_ri(3'b000, 1, 0, 5));
        emit(op_ri(3'b000, 2, 0, -1));
        emit(op_ri(3'b000, 31, 0, 32'h3ad));
        emit(br(3'b000, 1, 1, 8));
        emit(sw_w(31, 0, 32'h3f0));
        emit(br(3'b000, 1, 2, 8));
        emit(sw_w(1, 0, 32'h300));
        emit(br(3'b001, 1, 2, 8));
        emit(sw_w(31, 0, 32'h3f0));
        emit(br(3'b001, 1, 1, 8));
        emit(sw_w(1, 0, 32'h304));
        emit(br(3'b100, 2, 1, 8));
        emit(sw_w(31, 0, 32'h3f0));
        emit(br(3'b100, 1, 2, 8));
        emit(sw_w(1, 0, 32'h308));
        emit(br(3'b101, 1, 2, 8));
        emit(sw_w(31, 0, 32'h3f0));
        emit(br(3'b101, 2, 1, 8));
        emit(sw_w(1, 0, 32'h30c));
        for (int i = 0; i < 4; i++) begin
            expect_store(32'h300 + i * 4, 32'h0000_0005);
        end

        start_test(4, "branch_unsigned");
        emit(op_ri(3'b000, 1, 0, 5));
        emit(op_ri(3'b000, 2, 0, -1));
        emit(op_ri(3'b000, 31, 0, 32'h3ad));
        emit(br(3'b110, 1, 2, 8));
        emit(sw_w(31, 0, 32'h3f0));
        emit(br(3'b110, 2, 1, 8));
        emit(sw_w(1, 0, 32'h310));
        emit(br(3'b111, 2, 1, 8));
        emit(sw_w(31, 0, 32'h3f0));
        emit(br(3'b111, 1, 2, 8));
        emit(sw_w(1, 0, 32'h314));
        expect_store(32'h310, 32'h0000_0005);
        expect_store(32'h314, 32'h0000_0005);

        // Jumps followed by the x0 discard
        start_test(5, "jump_x0");
        emit(jal_w(1, 8));
        emit(sw_w(0, 0, 32'h3f0));
        emit(sw_w(1, 0, 32'h320));
        emit(op_ri(3'b000, 2, 0, 28));
        emit(jalr_w(3, 2, 0));
        emit(sw_w(0, 0, 32'h3f0));
        emit(sw_w(0, 0, 32'h3f0));
        emit(sw_w(3, 0, 32'h324));
        emit(op_ri(3'b000, 4, 0, 45));
        emit(jalr_w(5, 4, 0));
        emit(sw_w(0, 0, 32'h3f0));
        emit(sw_w(5, 0, 32'h328));
        emit(op_ri(3'b000, 0, 0, 123));
        emit(upper(20'h12345, 0, 7'b0110111));
        emit(sw_w(0, 0, 32'h330));
        expect_store(32'h320, 32'h0000_0004);
        expect_store(32'h324, 32'h0000_0014);
        expect_store(32'h328, 32'h0000_0028);
        expect_store(32'h330, 32'h0000_0000);
    endtask

    ////////////////////
    // Test loop
    ////////////////////
    initial begin
        int cycles;
        clk = 1'b0;
        rst = 1'b1;
        imem_rdata = 32'h0000_0013;
        dmem_rdata = '0;
        ia_q = '0;
        da_q = '0;
        re_q = 1'b0;
        cur_len = 0;
        passed = 0;
        failed = 0;
        build_tests();
        for (int t = 0; t < NUM_TESTS; t++) begin
            test_errors = 0;
            reset_and_load(t);
            cycles = 0;
            while (seen.size() < exp_counts[t] && cycles < 400) begin
                @(posedge clk);
                cycles++;
            end
            if (seen.size() < exp_counts[t]) begin
                $display("%s: stores never arrived, saw %0d of %0d", test_names[t],
                         seen.size(), exp_counts[t]);
                test_errors++;
            end
            for (int i = 0; i < exp_counts[t] && i < seen.size(); i++) begin
                check_value(test_names[t], "store address", exp_stores[t][i].addr,
                            seen[i].addr);
                check_value(test_names[t], "store data", exp_stores[t][i].data,
                            seen[i].data);
            end
            // Nothing further may be stored
            repeat (20) @(posedge clk);
            if (seen.size() > exp_counts[t]) begin
                $display("%s: %0d unexpected extra stores", test_names[t],
                         seen.size() - exp_counts[t]);
                test_errors++;
            end
            if (test_errors == 0) begin
                $display("%s: ok", test_names[t]);
                passed++;
            end else begin
                $display("%s: failed with %0d errors", test_names[t], test_errors);
                failed++;
            end
        end
        $display("%0d tests, %0d passed, %0d failed", NUM_TESTS, passed, failed);
        if (failed == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+verif
hw/rv_isa_pkg.sv
hw/core_pkg.sv
hw/control_decoder.sv
hw/reg_file.sv
hw/forward_unit.sv
hw/alu.sv
hw/execute_stage.sv
hw/riscv_core.sv
verif/riscv_core_tb.sv
